//--- all.f
pad_pkg.sv
pad_if.sv
host_btn_regs.sv
pad_decode.sv
turbo_gen.sv
joypad_serial.sv
pad_top.sv
tb_pad_top.sv

//--- Bender.yml
package:
  name: pad_top

sources:
  - pad_pkg.sv
  - pad_if.sv
  - host_btn_regs.sv
  - pad_decode.sv
  - turbo_gen.sv
  - joypad_serial.sv
  - pad_top.sv
  - target: test
    files:
      - tb_pad_top.sv

//--- tb_pad_top.sv
`timescale 1ns/10ps

module tb_pad_top
  import pad_pkg::*;
();

  localparam int TURBO_PERIOD = 6;
  // roughly twice the summed test lengths
  localparam int TIMEOUT_CYCLES = 4000;

  logic        clk;
  logic        sys_resetn;
  logic [7:0]  host_addr;
  logic [7:0]  host_data;
  logic        host_write;
  logic [7:0]  raw0 [2];
  logic [7:0]  raw1 [2];
  logic        joypad_strobe;
  logic [1:0]  joypad_clock;
  logic [1:0]  joypad_data;
  // overrides the host has written so far
  nes_btn_t    ovr_exp [2];
  int          cycles = 0;

  pad_top #(
    .TURBO_PERIOD (TURBO_PERIOD)
  ) pad_top_i (
    .clk           (clk),
    .sys_resetn    (sys_resetn),
    .host_addr     (host_addr),
    .host_data     (host_data),
    .host_write    (host_write),
    .ds1_rx0       (raw0[0]),
    .ds1_rx1       (raw1[0]),
    .ds2_rx0       (raw0[1]),
    .ds2_rx1       (raw1[1]),
    .joypad_strobe (joypad_strobe),
    .joypad_clock  (joypad_clock),
    .joypad_data   (joypad_data)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  task automatic stop_fail();
    $display("TB FAILED");
    $fatal(1);
  endtask

  task automatic check_byte(input string name, input nes_btn_t exp, input nes_btn_t act);
    if (act !== exp) begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      stop_fail();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERR %s expected %b actual %b", name, exp, act);
      stop_fail();
    end
  endtask

  // expected joypad byte from raw active-low pad bytes
  function automatic nes_btn_t ref_btn(input logic [7:0] rx0, input logic [7:0] rx1,
                                       input nes_btn_t ovr, input logic a_fire,
                                       input logic b_fire);
    nes_btn_t res;
    res.r      = ~rx0[DS_RIGHT];
    res.l      = ~rx0[DS_LEFT];
    res.d      = ~rx0[DS_DOWN];
    res.u      = ~rx0[DS_UP];
    res.start  = ~rx0[DS_START];
    res.select = ~rx0[DS_SELECT];
    res.b      = ~rx1[DS_CROSS] | b_fire;
    res.a      = ~rx1[DS_CIRCLE] | a_fire;
    return nes_btn_t'(res | ovr);
  endfunction

  // strobe, then eight bits, a first; ends with the eighth fall pending
  task automatic read_pad(input int p, output nes_btn_t val);
    logic [7:0] bits;
    @(negedge clk);
    joypad_strobe = 1'b1;
    @(negedge clk);
    joypad_strobe = 1'b0;
    bits[0] = joypad_data[p];
    joypad_clock[p] = 1'b1;
    for (int i = 1; i < NES_BTN_W; i++) begin
      @(negedge clk);
      joypad_clock[p] = 1'b0;
      @(negedge clk);
      bits[i] = joypad_data[p];
      joypad_clock[p] = 1'b1;
    end
    @(negedge clk);
    joypad_clock[p] = 1'b0;
    val = nes_btn_t'(bits);
  endtask

  // read both players, no autofire expected
  task automatic check_both(input string name);
    nes_btn_t got;
    for (int p = 0; p < 2; p++) begin
      read_pad(p, got);
      check_byte(name, ref_btn(raw0[p], raw1[p], ovr_exp[p], 1'b0, 1'b0), got);
    end
  endtask

  // random pad bytes with square and triangle released
  task automatic rand_raw(input int p);
    @(negedge clk);
    raw0[p] = 8'($urandom);
    raw1[p] = 8'($urandom) | 8'h90;
  endtask

  task automatic host_wr(input logic [7:0] addr, input logic [7:0] data);
    @(negedge clk);
    host_addr  = addr;
    host_data  = data;
    host_write = 1'b1;
    @(negedge clk);
    host_write = 1'b0;
    if (addr == 8'h40) ovr_exp[0] = nes_btn_t'(data);
    else if (addr == 8'h41) ovr_exp[1] = nes_btn_t'(data);
  endtask

  // one strobe load, b needs a single shift; starts and ends on a falling edge
  task automatic quick_bit(input int p, input logic want_b, output logic v);
    joypad_strobe   = 1'b1;
    joypad_clock[p] = want_b;
    @(negedge clk);
    joypad_strobe   = 1'b0;
    joypad_clock[p] = 1'b0;
    @(negedge clk);
    v = joypad_data[p];
  endtask

  task automatic turbo_test(input int p, input logic on_b);
    logic     v;
    logic     prev;
    int       run;
    bit       first;
    bit       seen_hi;
    bit       seen_lo;
    nes_btn_t got;
    @(negedge clk);
    raw0[p] = 8'hFF;
    raw1[p] = on_b ? ~(8'h01 << DS_SQUARE) : ~(8'h01 << DS_TRIANGLE);
    first = 1'b1;
    run = 0;
    seen_hi = 1'b0;
    seen_lo = 1'b0;
    prev = 1'b0;
    // 22 samples end inside a high level of the wave
    for (int s = 0; s < 22; s++) begin
      quick_bit(p, on_b, v);
      if (v) seen_hi = 1'b1;
      else seen_lo = 1'b1;
      if (s > 0 && v !== prev) begin
        // first level is skipped, samples are 2 cycles apart
        if (!first && run * 2 < TURBO_PERIOD) begin
          $display("autofire level on player %0d lasted only %0d cycles", p + 1, run * 2);
          stop_fail();
        end
        first = 1'b0;
        run = 0;
      end
      prev = v;
      run++;
    end
    check_bit("turbo_seen_high", 1'b1, seen_hi);
    check_bit("turbo_seen_low", 1'b1, seen_lo);
    // released, only the plain face button counts after 2 cycles
    raw1[p] = 8'hFF;
    repeat (2) @(negedge clk);
    read_pad(p, got);
    check_byte("turbo_release_idle", ref_btn(raw0[p], raw1[p], ovr_exp[p], 0, 0), got);
    @(negedge clk);
    raw1[p] = on_b ? ~(8'h01 << DS_CROSS) : ~(8'h01 << DS_CIRCLE);
    read_pad(p, got);
    check_byte("turbo_release_pressed", ref_btn(raw0[p], raw1[p], ovr_exp[p], 0, 0), got);
  endtask

  // run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: tests still running after %0d clock cycles", cycles);
      stop_fail();
    end
  end

  initial begin
    nes_btn_t got;
    nes_btn_t exp;
    void'($urandom(5));
    sys_resetn    = 1'b0;
    host_addr     = 8'h00;
    host_data     = 8'h00;
    host_write    = 1'b0;
    joypad_strobe = 1'b0;
    joypad_clock  = 2'b00;
    for (int p = 0; p < 2; p++) begin
      raw0[p]    = 8'hFF;
      raw1[p]    = 8'hFF;
      ovr_exp[p] = '0;
    end
    repeat (5) @(negedge clk);
    sys_resetn = 1'b1;

    // idle after reset
    @(negedge clk);
    check_bit("reset_data_p1", 1'b0, joypad_data[0]);
    check_bit("reset_data_p2", 1'b0, joypad_data[1]);
    check_both("reset_read");

    // random pads, players independent
    repeat (40) begin
      rand_raw(0);
      rand_raw(1);
      check_both("random_raw");
    end

    // host overrides, foreign address ignored
    repeat (6) begin
      host_wr(8'h40, 8'($urandom));
      host_wr(8'h41, 8'($urandom));
      rand_raw(0);
      rand_raw(1);
      check_both("host_override");
      host_wr(8'h35, 8'($urandom));
      check_both("foreign_addr");
    end
    host_wr(8'h40, 8'h00);
    host_wr(8'h41, 8'h00);

    for (int p = 0; p < 2; p++) begin
      // all pressed, then shifted empty
      @(negedge clk);
      raw0[p] = 8'h00;
      raw1[p] = 8'h90;
      read_pad(p, got);
      check_byte("shift_full", ref_btn(raw0[p], raw1[p], ovr_exp[p], 0, 0), got);
      @(negedge clk);
      check_bit("shift_empty", 1'b0, joypad_data[p]);
      // strobe held high reloads every edge
      rand_raw(p);
      exp = ref_btn(raw0[p], raw1[p], ovr_exp[p], 0, 0);
      joypad_strobe = 1'b1;
      @(negedge clk);
      check_bit("strobe_hold_a", exp.a, joypad_data[p]);
      joypad_clock[p] = 1'b1;
      @(negedge clk);
      check_bit("strobe_hold_a", exp.a, joypad_data[p]);
      joypad_clock[p] = 1'b0;
      // a clock fall beats the reload for one edge
      @(negedge clk);
      check_bit("strobe_hold_fall", exp.b, joypad_data[p]);
      @(negedge clk);
      check_bit("strobe_hold_a", exp.a, joypad_data[p]);
      joypad_strobe = 1'b0;
    end

    // autofire b from square, a from triangle
    for (int p = 0; p < 2; p++) begin
      turbo_test(p, 1'b1);
      turbo_test(p, 1'b0);
    end

    $display("TB PASSED");
    $finish;
  end

endmodule

//--- pad_top.sv
`timescale 1ns/10ps

module pad_top
  import pad_pkg::*;
#(
  // about 100 Hz toggle at 27 MHz
  parameter int TURBO_PERIOD = 135000
) (
  input  logic       clk,
  input  logic       sys_resetn,
  input  logic [7:0] host_addr,
  input  logic [7:0] host_data,
  input  logic       host_write,
  input  logic [7:0] ds1_rx0,
  input  logic [7:0] ds1_rx1,
  input  logic [7:0] ds2_rx0,
  input  logic [7:0] ds2_rx1,
  input  logic       joypad_strobe,
  input  logic [1:0] joypad_clock,
  output logic [1:0] joypad_data
);

  // per-player raw bytes, index 0 is player 1
  ds_byte_t rx0 [2];
  ds_byte_t rx1 [2];
  // per-player host override bytes
  nes_btn_t ovr [2];

  assign rx0[0] = ds_byte_t'(ds1_rx0);
  assign rx1[0] = ds_byte_t'(ds1_rx1);
  assign rx0[1] = ds_byte_t'(ds2_rx0);
  assign rx1[1] = ds_byte_t'(ds2_rx1);

  // host override registers, shared by both players
  host_btn_regs u_host_regs (
    .clk        (clk),
    .sys_resetn (sys_resetn),
    .host_addr  (host_reg_e'(host_addr)),
    .host_data  (nes_btn_t'(host_data)),
    .host_write (host_write),
    .btn_p1     (ovr[0]),
    .btn_p2     (ovr[1])
  );

  // one decode, autofire and shift chain per player
  for (genvar i = 0; i < 2; i++) begin : g_player

    pad_if pif ();

    pad_decode u_decode (
      .rx0 (rx0[i]),
      .rx1 (rx1[i]),
      .pad (pif.decode_mp)
    );

    turbo_gen #(
      .TURBO_PERIOD (TURBO_PERIOD)
    ) u_turbo (
      .clk        (clk),
      .sys_resetn (sys_resetn),
      .pad        (pif.turbo_mp)
    );

    // strobe is common, each player has its own clock
    joypad_serial u_serial (
      .clk           (clk),
      .sys_resetn    (sys_resetn),
      .joypad_strobe (joypad_strobe),
      .joypad_clock  (joypad_clock[i]),
      .override      (ovr[i]),
      .pad           (pif.port_mp),
      .joypad_data   (joypad_data[i])
    );

  end

endmodule

//--- joypad_serial.sv
`timescale 1ns/10ps

module joypad_serial
  import pad_pkg::*;
(
  input  logic          clk,
  input  logic          sys_resetn,
  input  logic          joypad_strobe,
  input  logic          joypad_clock,
  input  nes_btn_t      override,
  pad_if.port_mp        pad,
  output logic          joypad_data
);

  // byte presented to the console on strobe
  nes_btn_t             load_byte;
  // shift register, bit 0 is on the wire
  logic [NES_BTN_W-1:0] shift_q;
  // joypad clock seen at the previous edge
  logic                 clk_q;
  logic                 clk_fall;

  // host override or'ed with the pad
  // autofire forces b and a on top of that
  always_comb begin
    load_byte   = override | pad.btn;
    load_byte.b = load_byte.b | pad.b_fire;
    load_byte.a = load_byte.a | pad.a_fire;
  end

  // high then low across two edges
  assign clk_fall = clk_q & ~joypad_clock;

  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      shift_q <= '0;
      clk_q   <= 1'b0;
    end else begin
      clk_q <= joypad_clock;
      // shift takes priority over a concurrent strobe
      if (clk_fall) begin
        shift_q <= {1'b0, shift_q[NES_BTN_W-1:1]};
      end else if (joypad_strobe) begin
        shift_q <= load_byte;
      end
    end
  end

  // no output flop, data follows the register directly
  assign joypad_data = shift_q[0];

endmodule

//--- turbo_gen.sv
`timescale 1ns/10ps

module turbo_gen #(
  parameter int TURBO_PERIOD = 135000
) (
  input  logic     clk,
  input  logic     sys_resetn,
  pad_if.turbo_mp  pad
);

  // counter wide enough for 0 .. TURBO_PERIOD-1
  localparam int CNT_W = (TURBO_PERIOD > 1) ? $clog2(TURBO_PERIOD) : 1;
  // terminal count, fire toggles here
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(TURBO_PERIOD - 1);

  // channel 0 is a, channel 1 is b
  logic [1:0]       req;
  logic [CNT_W-1:0] cnt_q [2];
  logic [1:0]       fire_q;

  assign req = {pad.b_req, pad.a_req};

  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      for (int i = 0; i < 2; i++) begin
        cnt_q[i] <= '0;
      end
      fire_q <= '0;
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (!req[i]) begin
          // released, park low with counter cleared
          cnt_q[i]  <= '0;
          fire_q[i] <= 1'b0;
        end else if (cnt_q[i] == CNT_LAST) begin
          // half period done
          cnt_q[i]  <= '0;
          fire_q[i] <= ~fire_q[i];
        end else begin
          cnt_q[i]  <= cnt_q[i] + 1'b1;
        end
      end
    end
  end

  // first high lands TURBO_PERIOD cycles after the request
  assign pad.a_fire = fire_q[0];
  assign pad.b_fire = fire_q[1];

endmodule

//--- pad_decode.sv
`timescale 1ns/10ps

module pad_decode
  import pad_pkg::*;
(
  input  ds_byte_t        rx0,
  input  ds_byte_t        rx1,
  pad_if.decode_mp        pad
);

  // active high copies of the raw bytes
  ds_byte_t hit0;
  ds_byte_t hit1;

  assign hit0 = ~rx0;
  assign hit1 = ~rx1;

  // direction pad and system buttons, all from byte 0
  assign pad.btn.r      = hit0[DS_RIGHT];
  assign pad.btn.l      = hit0[DS_LEFT];
  assign pad.btn.d      = hit0[DS_DOWN];
  assign pad.btn.u      = hit0[DS_UP];
  assign pad.btn.start  = hit0[DS_START];
  assign pad.btn.select = hit0[DS_SELECT];

  // face buttons from byte 1
  // cross acts as b
  assign pad.btn.b      = hit1[DS_CROSS];
  // circle acts as a
  assign pad.btn.a      = hit1[DS_CIRCLE];

  // square held, autofire on b
  assign pad.b_req      = hit1[DS_SQUARE];
  // triangle held, autofire on a
  assign pad.a_req      = hit1[DS_TRIANGLE];

endmodule

//--- host_btn_regs.sv
`timescale 1ns/10ps

module host_btn_regs
  import pad_pkg::*;
(
  input  logic      clk,
  input  logic      sys_resetn,
  input  host_reg_e host_addr,
  input  nes_btn_t  host_data,
  input  logic      host_write,
  output nes_btn_t  btn_p1,
  output nes_btn_t  btn_p2
);

  // per-register write enables
  logic wr_p1;
  logic wr_p2;

  // address decode, only on a write strobe
  always_comb begin
    wr_p1 = 1'b0;
    wr_p2 = 1'b0;
    if (host_write) begin
      case (host_addr)
        BTN_P1_REG: begin
          wr_p1 = 1'b1;
        end
        BTN_P2_REG: begin
          wr_p2 = 1'b1;
        end
        // any other address is for someone else
        default: begin
          wr_p1 = 1'b0;
          wr_p2 = 1'b0;
        end
      endcase
    end
  end

  // override bytes, visible the cycle after the write
  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      btn_p1 <= '0;
      btn_p2 <= '0;
    end else begin
      if (wr_p1) begin
        btn_p1 <= host_data;
      end
      if (wr_p2) begin
        btn_p2 <= host_data;
      end
    end
  end

endmodule

//--- pad_if.sv
`timescale 1ns/10ps

interface pad_if
  import pad_pkg::*;
();

  // mapped buttons, autofire not merged yet
  nes_btn_t btn;

  // autofire requests
  // a from triangle, b from square
  logic     a_req;
  logic     b_req;

  // autofire square waves
  logic     a_fire;
  logic     b_fire;

  // decoder side
  modport decode_mp (
    output btn,
    output a_req,
    output b_req
  );

  // autofire generator side
  modport turbo_mp (
    input  a_req,
    input  b_req,
    output a_fire,
    output b_fire
  );

  // joypad shift register side
  modport port_mp (
    input btn,
    input a_fire,
    input b_fire
  );

endinterface

//--- pad_pkg.sv
package pad_pkg;

  // one nes joypad byte, msb first as declared
  // the console shifts it out lsb first, so a goes out first
  typedef struct packed {
    logic r;
    logic l;
    logic d;
    logic u;
    logic start;
    logic select;
    logic b;
    logic a;
  } nes_btn_t;

  // shift register width, one bit per nes button
  localparam int NES_BTN_W = 8;

  // host register addresses
  typedef enum logic [7:0] {
    BTN_P1_REG = 8'h40,
    BTN_P2_REG = 8'h41
  } host_reg_e;

  // raw dualshock rx byte, active low
  typedef logic [7:0] ds_byte_t;

  // rx byte 0 bit positions
  localparam logic [2:0] DS_SELECT = 3'd0;
  localparam logic [2:0] DS_START  = 3'd3;
  localparam logic [2:0] DS_UP     = 3'd4;
  localparam logic [2:0] DS_RIGHT  = 3'd5;
  localparam logic [2:0] DS_DOWN   = 3'd6;
  localparam logic [2:0] DS_LEFT   = 3'd7;

  // rx byte 1 bit positions
  // shoulder buttons sit in the low nibble and are not mapped
  localparam logic [2:0] DS_TRIANGLE = 3'd4;
  localparam logic [2:0] DS_CIRCLE   = 3'd5;
  localparam logic [2:0] DS_CROSS    = 3'd6;
  localparam logic [2:0] DS_SQUARE   = 3'd7;

endpackage
